// ==== Bender.yml ====
package:
  name: approx_divider

sources:
  # packages first, then interface and RTL
  - files:
      - hw/div_arith_pkg.sv
      - hw/div_cell_pkg.sv
      - hw/div_stage_if.sv
      - hw/div_row.sv
      - hw/div_row_block.sv
      - hw/approx_divider.sv

  # testbench
  - target: test
    include_dirs:
      - tb
    files:
      - tb/approx_divider_tb.sv

// ==== approx_divider.f ====
hw/div_arith_pkg.sv
hw/div_cell_pkg.sv
hw/div_stage_if.sv
hw/div_row.sv
hw/div_row_block.sv
hw/approx_divider.sv
+incdir+tb
tb/approx_divider_tb.sv

// ==== hw/approx_divider.sv ====
`timescale 1ns/1ps

module approx_divider (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                in_valid,
  input  logic [div_arith_pkg::div_num_w-1:0] numerator,
  input  logic [div_arith_pkg::div_den_w-1:0] divisor,
  output logic                                out_valid,
  output logic [div_arith_pkg::div_den_w-1:0] quotient,
  output logic [div_arith_pkg::div_den_w-1:0] remainder
);
  import div_arith_pkg::*;

  localparam int rest_w = div_num_w - div_win_w;  // numerator bits below first window

  div_stage_if stage_in ();
  div_stage_if stage_mid ();
  div_stage_if stage_out ();

  //////////////////////////////////////////////////////////////////////
  // input capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_in.valid <= 1'b0;
    end else begin
      stage_in.valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      stage_in.win      <= numerator[div_num_w-1 -: div_win_w];  // row 7 window
      stage_in.num_rest <= div_den_w'(numerator[rest_w-1:0]);
      stage_in.divisor  <= divisor;
      stage_in.quot     <= '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // array blocks
  //////////////////////////////////////////////////////////////////////

  div_row_block #(
    .top_row    (div_rows - 1),
    .bottom_row (div_split_row + 1)
  ) u_upper (
    .clk   (clk),
    .rst_n (rst_n),
    .up    (stage_in.dst),
    .dn    (stage_mid.src)
  );

  div_row_block #(
    .top_row    (div_split_row),
    .bottom_row (0)
  ) u_lower (
    .clk   (clk),
    .rst_n (rst_n),
    .up    (stage_mid.dst),
    .dn    (stage_out.src)
  );

  assign out_valid = stage_out.valid;
  assign quotient  = stage_out.quot;
  assign remainder = stage_out.win[div_den_w-1:0];  // row 0 result

endmodule

// ==== hw/div_arith_pkg.sv ====
package div_arith_pkg;

  //////////////////////////////////////////////////////////////////////
  // operand widths
  //////////////////////////////////////////////////////////////////////

  localparam int div_num_w = 16;             // numerator
  localparam int div_den_w = 8;              // divisor, quotient and remainder
  localparam int div_win_w = div_den_w + 1;  // window into one array row

  //////////////////////////////////////////////////////////////////////
  // array shape and pipeline
  //////////////////////////////////////////////////////////////////////

  // one row per quotient bit, row 7 sees the numerator msbs
  localparam int div_rows = div_num_w - div_den_w;

  // rows 7..4 form the upper block, rows 3..0 the lower block
  localparam int div_split_row = 3;          // highest row of lower block

  // input capture plus one register per block
  localparam int div_latency = 3;

endpackage

// ==== hw/div_cell_pkg.sv ====
package div_cell_pkg;

  //////////////////////////////////////////////////////////////////////
  // subtract cell kinds
  //////////////////////////////////////////////////////////////////////

  // exact cell   diff = x ^ y ^ bin
  //              bout = (~x & y) | (~(x ^ y) & bin)
  // approx cell  diff = x | ~y
  //              bout = y | (~x & bin)
  typedef enum logic {
    cell_exact  = 1'b0,
    cell_approx = 1'b1
  } cell_kind_e;

  // low rows only weigh the lsbs of the quotient
  localparam int div_approx_rows = 6;  // rows 0..5

  //////////////////////////////////////////////////////////////////////
  // row to cell kind mapping
  //////////////////////////////////////////////////////////////////////

  function automatic cell_kind_e cell_kind_of_row(input int row);
    cell_kind_e kind;
    if (row < div_approx_rows) begin
      kind = cell_approx;
    end else begin
      kind = cell_exact;
    end
    return kind;
  endfunction

endpackage

// ==== hw/div_row.sv ====
`timescale 1ns/1ps

module div_row #(
  parameter int row = 0
) (
  input  logic [div_arith_pkg::div_win_w-1:0] win,
  input  logic [div_arith_pkg::div_den_w-1:0] divisor,
  output logic [div_arith_pkg::div_den_w-1:0] rem_out,
  output logic                                q_bit
);
  import div_arith_pkg::*;
  import div_cell_pkg::*;

  localparam cell_kind_e kind = cell_kind_of_row(row);

  logic [div_den_w:0]   borrow;  // borrow[k] feeds cell k
  logic [div_den_w-1:0] diff;

  assign borrow[0] = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // subtract cells, lsb first
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < div_den_w; k++) begin : g_cell
    if (kind == cell_approx) begin : g_approx
      assign diff[k]     = win[k] | ~divisor[k];
      assign borrow[k+1] = divisor[k] | (~win[k] & borrow[k]);
    end else begin : g_exact
      assign diff[k]     = win[k] ^ divisor[k] ^ borrow[k];
      assign borrow[k+1] = (~win[k] & divisor[k]) |
                           (~(win[k] ^ divisor[k]) & borrow[k]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // quotient bit and restoring select
  //////////////////////////////////////////////////////////////////////

  // a set window msb means the window already exceeds the divisor
  assign q_bit = win[div_den_w] | ~borrow[div_den_w];

  always_comb begin
    if (q_bit) begin
      rem_out = diff;                  // subtraction kept
    end else begin
      rem_out = win[div_den_w-1:0];    // restore
    end
  end

endmodule

// ==== hw/div_row_block.sv ====
`timescale 1ns/1ps

module div_row_block #(
  parameter int top_row    = 7,
  parameter int bottom_row = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  div_stage_if.dst up,
  div_stage_if.src dn
);
  import div_arith_pkg::*;

  localparam int n_rows = top_row - bottom_row + 1;

  logic [div_win_w-1:0]  row_win [bottom_row:top_row];
  logic [div_den_w-1:0]  row_rem [bottom_row:top_row];
  logic [top_row:bottom_row] row_q;

  logic [div_win_w-1:0]  next_win;
  logic [div_den_w-1:0]  next_num_rest;
  logic [div_den_w-1:0]  next_quot;

  //////////////////////////////////////////////////////////////////////
  // row chain
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < n_rows; i++) begin : g_row
    localparam int r = top_row - i;

    if (r == top_row) begin : g_first
      assign row_win[r] = up.win;  // window prepared by previous stage
    end else begin : g_next
      assign row_win[r] = {row_rem[r+1], up.num_rest[r]};
    end

    div_row #(
      .row(r)
    ) u_row (
      .win     (row_win[r]),
      .divisor (up.divisor),
      .rem_out (row_rem[r]),
      .q_bit   (row_q[r])
    );
  end

  // window for the row below this block, or the bare remainder at the end
  if (bottom_row == 0) begin : g_last
    assign next_win = {1'b0, row_rem[bottom_row]};
  end else begin : g_handoff
    assign next_win = {row_rem[bottom_row], up.num_rest[bottom_row-1]};
  end

  always_comb begin
    for (int b = 0; b < div_den_w; b++) begin
      next_num_rest[b] = (b < bottom_row - 1) ? up.num_rest[b] : 1'b0;  // drop used bits
    end
  end

  always_comb begin
    next_quot                     = up.quot;
    next_quot[top_row:bottom_row] = row_q;
  end

  //////////////////////////////////////////////////////////////////////
  // stage register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dn.valid <= 1'b0;
    end else begin
      dn.valid <= up.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (up.valid) begin  // hold data in idle cycles
      dn.win      <= next_win;
      dn.num_rest <= next_num_rest;
      dn.divisor  <= up.divisor;
      dn.quot     <= next_quot;
    end
  end

endmodule

// ==== hw/div_stage_if.sv ====
`timescale 1ns/1ps

interface div_stage_if;
  import div_arith_pkg::*;

  logic                 valid;
  logic [div_win_w-1:0] win;       // window for the next row
  logic [div_den_w-1:0] num_rest;  // numerator bits not yet shifted in
  logic [div_den_w-1:0] divisor;
  logic [div_den_w-1:0] quot;      // quotient bits resolved so far

  modport src (
    output valid,
    output win,
    output num_rest,
    output divisor,
    output quot
  );

  modport dst (
    input valid,
    input win,
    input num_rest,
    input divisor,
    input quot
  );

endinterface

// ==== tb/div_ref_model.svh ====
`ifndef div_ref_model_svh
`define div_ref_model_svh

//////////////////////////////////////////////////////////////////////
// bit-level model of the subtract array
//////////////////////////////////////////////////////////////////////

localparam int model_approx_rows = 6;  // rows 0..5 are approximate

// one cell, exact or approximate
function automatic void model_cell(input bit approx, input bit x, input bit y,
                                   input bit bin, output bit diff, output bit bout);
  if (approx) begin
    diff = x | ~y;
    bout = y | (~x & bin);
  end else begin
    diff = x ^ y ^ bin;
    bout = (~x & y) | (~(x ^ y) & bin);
  end
endfunction

// one row with its restoring select
function automatic void model_row(input int row, input bit [8:0] win, input bit [7:0] d,
                                  output bit [7:0] rem, output bit q);
  bit       b;
  bit       dbit;
  bit [7:0] diff;
  b = 1'b0;
  for (int k = 0; k < 8; k++) begin
    model_cell(row < model_approx_rows, win[k], d[k], b, dbit, b);
    diff[k] = dbit;
  end
  q = win[8] | ~b;
  rem = q ? diff : win[7:0];
endfunction

// whole array, row 7 first
function automatic void model_divide(input bit [15:0] n, input bit [7:0] d,
                                     output bit [7:0] q, output bit [7:0] r);
  bit [8:0] win;
  bit [7:0] rem;
  bit       qb;
  win = n[15:7];
  rem = '0;
  for (int row = 7; row >= 0; row--) begin
    if (row < 7) begin
      win = {rem, n[row]};
    end
    model_row(row, win, d, rem, qb);
    q[row] = qb;
  end
  r = rem;
endfunction

`endif

// ==== tb/approx_divider_tb.sv ====
`timescale 1ns/1ps

module approx_divider_tb;
  import div_arith_pkg::*;

  `include "div_ref_model.svh"

  localparam int reset_cycles = 16;
  localparam int burst_len    = 16;
  localparam int random_len   = 200;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        in_valid;
  logic [15:0] numerator;
  logic [7:0]  divisor;
  logic        out_valid;
  logic [7:0]  quotient;
  logic [7:0]  remainder;

  logic [15:0] c_num [$];  // directed cases from the data file
  logic [7:0]  c_den [$];
  logic [7:0]  c_quot [$];
  logic [7:0]  c_rem [$];

  logic [7:0]  exp_quot [$];  // operations in flight
  logic [7:0]  exp_rem [$];
  int          exp_cyc [$];

  int cyc;
  int errors;
  int checks;
  int tests;
  int limit_cycles;

  approx_divider dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .numerator (numerator),
    .divisor   (divisor),
    .out_valid (out_valid),
    .quotient  (quotient),
    .remainder (remainder)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  task automatic issue(input logic [15:0] n, input logic [7:0] d,
                       input logic [7:0] eq, input logic [7:0] er);
    @(posedge clk);
    in_valid  <= 1'b1;
    numerator <= n;
    divisor   <= d;
    exp_quot.push_back(eq);
    exp_rem.push_back(er);
    exp_cyc.push_back(cyc);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic drain();
    idle_cycle();
    while (exp_quot.size() != 0) begin
      idle_cycle();
    end
    idle_cycle();
  endtask

  task automatic issue_random();
    bit [15:0] n;
    bit [7:0]  d;
    bit [7:0]  q;
    bit [7:0]  r;
    n = $urandom;
    d = $urandom;
    model_divide(n, d, q, r);
    issue(n, d, q, r);
  endtask

  task automatic report(input string name, input int ops, input int err_before);
    tests++;
    $display("test %s: %0d operations, %0d errors", name, ops, errors - err_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // output monitor, sampled on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (out_valid === 1'b1) begin
      if (exp_quot.size() == 0) begin
        $display("out_valid high at cycle %0d with no operation in flight", cyc);
        errors++;
      end else begin
        checks++;
        if (cyc - exp_cyc[0] != div_latency) begin
          $display("result came %0d cycles after issue instead of %0d",
                   cyc - exp_cyc[0], div_latency);
          errors++;
        end
        if (quotient !== exp_quot[0]) begin
          $display("error quotient expected %h got %h", exp_quot[0], quotient);
          errors++;
        end
        if (remainder !== exp_rem[0]) begin
          $display("error remainder expected %h got %h", exp_rem[0], remainder);
          errors++;
        end
        void'(exp_quot.pop_front());
        void'(exp_rem.pop_front());
        void'(exp_cyc.pop_front());
      end
    end else if (out_valid !== 1'b0) begin
      $display("out_valid is unknown at cycle %0d", cyc);
      errors++;
    end
    cyc = cyc + 1;
  end

  // watchdog
  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout after %0d cycles, the DUT stopped producing results", limit_cycles);
    $display("Regression failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          err_before;
    string       line;
    logic [15:0] n;
    logic [7:0]  d;
    logic [7:0]  q;
    logic [7:0]  r;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    numerator    = '0;
    divisor      = '0;
    cyc          = 0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    limit_cycles = 0;
    void'($urandom(38));

    fd = $fopen("tb/div_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the directed case file tb/div_cases.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if ($sscanf(line, "%h %h %h %h", n, d, q, r) == 4) begin
          c_num.push_back(n);
          c_den.push_back(d);
          c_quot.push_back(q);
          c_rem.push_back(r);
        end
      end
      $fclose(fd);
    end

    limit_cycles = 2 * (reset_cycles + c_num.size() + burst_len + random_len + div_latency);

    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) idle_cycle();  // out_valid must stay low here

    // isolated pulses from the data file
    err_before = errors;
    for (int i = 0; i < c_num.size(); i++) begin
      issue(c_num[i], c_den[i], c_quot[i], c_rem[i]);
      drain();
    end
    report("directed", c_num.size(), err_before);

    // back to back, three in flight at a time
    err_before = errors;
    for (int i = 0; i < burst_len; i++) begin
      issue_random();
    end
    drain();
    report("burst", burst_len, err_before);

    // random operands with random idle gaps
    err_before = errors;
    for (int i = 0; i < random_len; i++) begin
      if ($urandom_range(3) == 0) begin
        idle_cycle();
      end
      issue_random();
    end
    drain();
    report("random", random_len, err_before);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== tb/div_cases.txt ====
# numerator divisor quotient remainder, all hex
# expected values follow the array with approximate rows 0..5
0000 01 00 00
0000 00 ff ff
ffff 00 ff ff
1234 00 ff ff
0000 ff 00 00
4000 80 80 00
4041 80 80 41
00ff 80 00 ff
01ff 80 01 ff
8000 80 ef ff
0003 01 01 ff
8000 01 ff fe
2000 40 80 00
1000 40 40 00
0800 40 1f ff
ffff ff 80 7f
7f80 ff 80 00
0006 03 01 fe
0180 03 80 00
0100 02 80 00
